// ==== tb.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/line_buffer.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
verification/axi_rd_mem.sv
verification/tb_fetch.sv

// ==== run.sh ====
#!/bin/bash
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f tb.f
./obj_dir/Vtb_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

// ==== verification/tb_fetch.sv ====
`include "fetch_defines.svh"

module tb_fetch;

    localparam logic [`FETCH_DATA_W-1:0] DATA_MASK = 32'h5a5a_0000;
    // pairs each test waits for
    localparam int LEN_SEQ   = 32;
    localparam int LEN_STALL = 24;
    localparam int LEN_PRIO  = 16;
    localparam int LEN_BURST = 16;
    localparam int WATCHDOG_CYCLES = (LEN_SEQ + LEN_STALL + LEN_PRIO + LEN_BURST) * 64;

    logic                     aclk = 1'b0;
    logic                     aresetn;
    fetch_pkg::redirect_t     i_redirect_wb;
    fetch_pkg::redirect_t     i_redirect_ex;
    fetch_pkg::redirect_t     i_redirect_id;
    fetch_pkg::axi_ar_t       o_ar;
    logic                     o_arvalid;
    logic                     i_arready;
    fetch_pkg::axi_r_t        i_r;
    logic                     i_rvalid;
    logic                     o_rready;
    logic                     o_pair_valid;
    fetch_pkg::fetch_pair_t   o_pair;
    logic                     i_pair_ready;

    integer                   seed = 32'h76b6;
    logic                     ready_rand;
    logic                     any_redirect;
    logic [`FETCH_ADDR_W-1:0] redirect_target;
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [`FETCH_ADDR_W-1:0] last_ar_addr;
    int                       xfer_cnt;
    int                       skip_ar;
    int                       beat_cnt;
    logic                     burst_open;
    logic                     stall_prev;
    fetch_pkg::fetch_pair_t   held_pair;
    int                       errors = 0;
    int                       err_mark = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;

    always #2 aclk = ~aclk;

    fetch_top uut (.*);

    axi_rd_mem u_mem (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_ar      (o_ar),
        .i_arvalid (o_arvalid),
        .o_arready (i_arready),
        .o_r       (i_r),
        .o_rvalid  (i_rvalid),
        .i_rready  (o_rready)
    );

    assign any_redirect = i_redirect_wb.valid | i_redirect_ex.valid | i_redirect_id.valid;
    assign redirect_target = i_redirect_wb.valid ? i_redirect_wb.target :
                             i_redirect_ex.valid ? i_redirect_ex.target : i_redirect_id.target;

    always @(posedge aclk) begin
        i_pair_ready <= ready_rand && ($random(seed) % 4 != 0);
    end

    // expected stream, burst and stall bookkeeping
    always @(posedge aclk) begin
        if (!aresetn) begin
            exp_pc       <= `RESET_PC;
            last_ar_addr <= `RESET_PC - 32'd64;
            xfer_cnt     <= 0;
            skip_ar      <= 0;
            beat_cnt     <= 0;
            burst_open   <= 1'b0;
            stall_prev   <= 1'b0;
        end else begin
            if (o_pair_valid && i_pair_ready) begin
                xfer_cnt <= xfer_cnt + 1;
            end
            if (any_redirect) begin
                exp_pc <= redirect_target;
            end else if (o_pair_valid && i_pair_ready) begin
                exp_pc <= exp_pc + 32'd8;
            end
            if (o_arvalid && i_arready) begin
                last_ar_addr <= o_ar.addr;
                burst_open   <= 1'b1;
                if (skip_ar > 0) begin
                    skip_ar <= skip_ar - 1;
                end
            end
            // the pending request and the target's own one leave the old sequence
            if (any_redirect) begin
                skip_ar <= 2;
            end
            if (i_rvalid && o_rready) begin
                beat_cnt <= i_r.last ? 0 : beat_cnt + 1;
                if (i_r.last) begin
                    burst_open <= 1'b0;
                end
            end
            stall_prev <= o_pair_valid && !i_pair_ready && !any_redirect;
            held_pair  <= o_pair;
        end
    end

    a_reset_idle: assert property (@(posedge aclk)
        $rose(aresetn) |-> !o_arvalid && !o_rready && !o_pair_valid)
        else report_mismatch("outputs after reset", 0, $sampled({o_arvalid, o_rready, o_pair_valid}));
    a_pair_pc: assert property (@(posedge aclk) disable iff (!aresetn)
        o_pair_valid && i_pair_ready |-> o_pair.pc == exp_pc)
        else report_mismatch("o_pair.pc", $sampled(exp_pc), $sampled(o_pair.pc));
    a_inst0: assert property (@(posedge aclk) disable iff (!aresetn)
        o_pair_valid && i_pair_ready |-> o_pair.inst0 == (exp_pc ^ DATA_MASK))
        else report_mismatch("o_pair.inst0", $sampled(exp_pc) ^ DATA_MASK, $sampled(o_pair.inst0));
    a_inst1: assert property (@(posedge aclk) disable iff (!aresetn)
        o_pair_valid && i_pair_ready |-> o_pair.inst1 == ((exp_pc + 32'd4) ^ DATA_MASK))
        else report_mismatch("o_pair.inst1", ($sampled(exp_pc) + 32'd4) ^ DATA_MASK,
                             $sampled(o_pair.inst1));
    a_ar_shape: assert property (@(posedge aclk) disable iff (!aresetn)
        o_arvalid |-> {o_ar.id, o_ar.len, o_ar.size, o_ar.burst, o_ar.addr[5:0]} ==
                      {4'(`FETCH_AXI_ID), 8'd15, 3'd2, 2'(`AXI_BURST_INCR), 6'd0})
        else report_mismatch("o_ar id/len/size/burst/addr[5:0]",
                             {4'(`FETCH_AXI_ID), 8'd15, 3'd2, 2'(`AXI_BURST_INCR), 6'd0},
                             $sampled({o_ar.id, o_ar.len, o_ar.size, o_ar.burst, o_ar.addr[5:0]}));
    a_ar_next_line: assert property (@(posedge aclk) disable iff (!aresetn)
        o_arvalid && i_arready && skip_ar == 0 |-> o_ar.addr == last_ar_addr + 32'd64)
        else report_mismatch("o_ar.addr", $sampled(last_ar_addr) + 32'd64, $sampled(o_ar.addr));
    a_valid_held: assert property (@(posedge aclk) disable iff (!aresetn)
        stall_prev |-> o_pair_valid)
        else report_mismatch("o_pair_valid", 1, 0);
    a_pair_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        stall_prev |-> o_pair == held_pair)
        else report_mismatch("o_pair", $sampled(held_pair), $sampled(o_pair));
    a_rready_open: assert property (@(posedge aclk) disable iff (!aresetn)
        o_rready == burst_open)
        else report_mismatch("o_rready", $sampled(burst_open), $sampled(o_rready));
    a_burst_done: assert property (@(posedge aclk) disable iff (!aresetn)
        o_arvalid && i_arready |-> !burst_open && beat_cnt == 0)
        else count_failure("a new AR was accepted before the previous burst took all 16 beats");

    task automatic report_mismatch(input string name, input logic [95:0] expected,
                                   input logic [95:0] actual);
        errors = errors + 1;
        $display("FAILED %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic count_failure(input string msg);
        errors = errors + 1;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic wait_transfers(input int n);
        int target;
        target = xfer_cnt + n;
        while (xfer_cnt < target) begin
            @(posedge aclk);
        end
    endtask

    function automatic fetch_pkg::redirect_t make_redirect(input logic [`FETCH_ADDR_W-1:0] pc);
        make_redirect = {1'b1, pc};
    endfunction

    // redirects are valid for exactly one cycle
    task automatic send_redirect(input fetch_pkg::redirect_t wb, input fetch_pkg::redirect_t ex,
                                 input fetch_pkg::redirect_t id);
        @(posedge aclk);
        i_redirect_wb <= wb;
        i_redirect_ex <= ex;
        i_redirect_id <= id;
        @(posedge aclk);
        i_redirect_wb <= '0;
        i_redirect_ex <= '0;
        i_redirect_id <= '0;
    endtask

    task automatic finish_test(input string name);
        tests_run = tests_run + 1;
        if (errors != err_mark) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "pass" : "fail");
        err_mark = errors;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

    initial begin
        aresetn       = 1'b0;
        i_redirect_wb = '0;
        i_redirect_ex = '0;
        i_redirect_id = '0;
        i_pair_ready  = 1'b0;
        ready_rand    = 1'b0;
        repeat (5) @(posedge aclk);
        aresetn    <= 1'b1;
        ready_rand <= 1'b1;

        wait_transfers(LEN_SEQ);
        finish_test("sequential fetch from reset");

        // long enough for the queue to fill
        ready_rand <= 1'b0;
        repeat (60) @(posedge aclk);
        ready_rand <= 1'b1;
        wait_transfers(LEN_STALL);
        finish_test("decoder back-pressure");

        send_redirect(make_redirect(32'h2000), make_redirect(32'h3008), make_redirect(32'h4010));
        wait_transfers(LEN_PRIO / 2);
        send_redirect('0, make_redirect(32'h5018), make_redirect(32'h6020));
        wait_transfers(LEN_PRIO / 2);
        finish_test("redirect priority");

        while (!o_rready) begin
            @(posedge aclk);
        end
        send_redirect('0, '0, make_redirect(32'h7030));
        wait_transfers(LEN_BURST);
        finish_test("redirect during open burst");

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/axi_rd_mem.sv ====
`include "fetch_defines.svh"

module axi_rd_mem #(
    parameter logic [31:0] SEED = 32'h76b6
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  fetch_pkg::axi_ar_t i_ar,
    input  logic              i_arvalid,
    output logic              o_arready,
    output fetch_pkg::axi_r_t o_r,
    output logic              o_rvalid,
    input  logic              i_rready
);

    localparam logic [`FETCH_DATA_W-1:0] DATA_MASK = 32'h5a5a_0000;

    integer                   seed;
    logic [31:0]              rnd;
    logic                     busy;
    logic [`FETCH_ADDR_W-1:0] addr;
    logic [7:0]               left;
    logic [`AXI_ID_W-1:0]     id;

    initial begin
        seed      = SEED;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_r       = '0;
    end

    always @(posedge aclk) begin
        rnd = $random(seed);
        if (!aresetn) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            // one burst at a time
            o_arready <= !busy && !(i_arvalid && o_arready) && rnd[0];
            if (i_arvalid && o_arready) begin
                busy <= 1'b1;
                addr <= i_ar.addr;
                left <= i_ar.len;
                id   <= i_ar.id;
            end
            if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
                if (o_r.last) begin
                    busy <= 1'b0;
                end
            end
            // next beat, back to back when the random bits allow
            if (busy && (!o_rvalid || (i_rready && !o_r.last)) && rnd[2:1] != 2'b00) begin
                o_rvalid <= 1'b1;
                o_r.id   <= id;
                o_r.data <= addr ^ DATA_MASK;
                o_r.resp <= 2'b00;
                o_r.last <= (left == 8'd0);
                addr     <= addr + 32'd4;
                left     <= left - 8'd1;
            end
        end
    end

endmodule

// ==== verilog/fetch_top.sv ====
`include "fetch_defines.svh"

module fetch_top (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  fetch_pkg::redirect_t   i_redirect_wb,
    input  fetch_pkg::redirect_t   i_redirect_ex,
    input  fetch_pkg::redirect_t   i_redirect_id,
    output fetch_pkg::axi_ar_t     o_ar,
    output logic                   o_arvalid,
    input  logic                   i_arready,
    input  fetch_pkg::axi_r_t      i_r,
    input  logic                   i_rvalid,
    output logic                   o_rready,
    output logic                   o_pair_valid,
    output fetch_pkg::fetch_pair_t o_pair,
    input  logic                   i_pair_ready
);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     flush;
    logic                     push;
    logic                     queue_full;
    fetch_pkg::fetch_pair_t   push_pair;

    pc_gen u_pc_gen (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_redirect_wb (i_redirect_wb),
        .i_redirect_ex (i_redirect_ex),
        .i_redirect_id (i_redirect_id),
        .i_advance     (push),
        .o_pc          (pc),
        .o_flush       (flush)
    );

    line_buffer u_line_buffer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_pc      (pc),
        .i_flush   (flush),
        .i_full    (queue_full),
        .i_arready (i_arready),
        .i_r       (i_r),
        .i_rvalid  (i_rvalid),
        .o_push    (push),
        .o_pair    (push_pair),
        .o_ar      (o_ar),
        .o_arvalid (o_arvalid),
        .o_rready  (o_rready)
    );

    fetch_queue u_fetch_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_flush (flush),
        .i_push  (push),
        .i_pair  (push_pair),
        .i_ready (i_pair_ready),
        .o_full  (queue_full),
        .o_valid (o_pair_valid),
        .o_pair  (o_pair)
    );

endmodule

// ==== verilog/fetch_queue.sv ====
`include "fetch_defines.svh"

module fetch_queue (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   i_flush,
    input  logic                   i_push,
    input  fetch_pkg::fetch_pair_t i_pair,
    input  logic                   i_ready,
    output logic                   o_full,
    output logic                   o_valid,
    output fetch_pkg::fetch_pair_t o_pair
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    fetch_pkg::fetch_pair_t mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [PTR_W:0]         count;
    logic                   pop;

    assign pop     = o_valid && i_ready;
    assign o_full  = (count == (PTR_W + 1)'(`QUEUE_DEPTH));
    assign o_valid = (count != '0);
    assign o_pair  = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (!aresetn || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_pair;
        end
    end

    // line_buffer must honour o_full
    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        i_push |-> !o_full);

endmodule

// ==== verilog/line_buffer.sv ====
`include "fetch_defines.svh"

module line_buffer (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic [`FETCH_ADDR_W-1:0] i_pc,
    input  logic                     i_flush,
    input  logic                     i_full,
    input  logic                     i_arready,
    input  fetch_pkg::axi_r_t        i_r,
    input  logic                     i_rvalid,
    output logic                     o_push,
    output fetch_pkg::fetch_pair_t   o_pair,
    output fetch_pkg::axi_ar_t       o_ar,
    output logic                     o_arvalid,
    output logic                     o_rready
);

    localparam int TAG_W = `FETCH_ADDR_W - `LINE_OFFSET_W;
    localparam int IDX_W = `LINE_OFFSET_W - 2;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_FILL
    } state_t;

    state_t                   state;
    logic [`FETCH_DATA_W-1:0] line_mem [`LINE_WORDS];
    logic [TAG_W-1:0]         line_tag;
    logic                     line_valid;
    logic [IDX_W-1:0]         beat_cnt;
    logic                     hit;
    logic                     beat;
    logic [IDX_W-1:0]         idx_lo;
    logic [IDX_W-1:0]         idx_hi;

    assign hit  = line_valid && (line_tag == i_pc[`FETCH_ADDR_W-1:`LINE_OFFSET_W]);
    assign beat = i_rvalid && o_rready;

    // word pair addressed by the pc
    assign idx_lo = {i_pc[`LINE_OFFSET_W-1:3], 1'b0};
    assign idx_hi = {i_pc[`LINE_OFFSET_W-1:3], 1'b1};

    // a redirect drops the pair being offered this cycle
    assign o_push       = hit && !i_full && !i_flush;
    assign o_pair.pc    = i_pc;
    assign o_pair.inst0 = line_mem[idx_lo];
    assign o_pair.inst1 = line_mem[idx_hi];

    assign o_ar.id    = `AXI_ID_W'(`FETCH_AXI_ID);
    assign o_ar.addr  = {line_tag, {`LINE_OFFSET_W{1'b0}}};
    assign o_ar.len   = 8'(`AXI_LEN_LINE);
    assign o_ar.size  = 3'(`AXI_SIZE_WORD);
    assign o_ar.burst = 2'(`AXI_BURST_INCR);

    assign o_arvalid = (state == S_REQ);
    assign o_rready  = (state == S_FILL);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= S_IDLE;
            line_valid <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!hit) begin
                        state      <= S_REQ;
                        line_valid <= 1'b0;
                    end
                end
                S_REQ: begin
                    if (i_arready) begin
                        state <= S_FILL;
                    end
                end
                S_FILL: begin
                    // burst always completes, even across a redirect
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (i_r.last) begin
                            state      <= S_IDLE;
                            line_valid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // tag of the line being fetched, latched with the miss
    always_ff @(posedge aclk) begin
        if (state == S_IDLE && !hit) begin
            line_tag <= i_pc[`FETCH_ADDR_W-1:`LINE_OFFSET_W];
        end
    end

    always_ff @(posedge aclk) begin
        if (beat) begin
            line_mem[beat_cnt] <= i_r.data;
        end
    end

    a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar));

    // slave must close the burst on the sixteenth beat, no sooner or later
    a_last_beat: assert property (@(posedge aclk) disable iff (!aresetn)
        beat |-> (i_r.last == (beat_cnt == IDX_W'(`LINE_WORDS - 1))));

endmodule

// ==== verilog/pc_gen.sv ====
`include "fetch_defines.svh"

module pc_gen (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  fetch_pkg::redirect_t     i_redirect_wb,
    input  fetch_pkg::redirect_t     i_redirect_ex,
    input  fetch_pkg::redirect_t     i_redirect_id,
    input  logic                     i_advance,
    output logic [`FETCH_ADDR_W-1:0] o_pc,
    output logic                     o_flush
);

    localparam logic [`FETCH_ADDR_W-1:0] PAIR_BYTES = `FETCH_ADDR_W'(8);

    fetch_pkg::redirect_t sel;

    // writeback beats execute beats decode
    always_comb begin
        if (i_redirect_wb.valid) begin
            sel = i_redirect_wb;
        end else if (i_redirect_ex.valid) begin
            sel = i_redirect_ex;
        end else begin
            sel = i_redirect_id;
        end
    end

    assign o_flush = i_redirect_wb.valid | i_redirect_ex.valid | i_redirect_id.valid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_pc <= `RESET_PC;
        end else if (o_flush) begin
            o_pc <= sel.target;
        end else if (i_advance) begin
            o_pc <= o_pc + PAIR_BYTES;
        end
    end

    // pairs are fetched whole, so a target inside a pair breaks the line lookup
    a_redirect_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        (!i_redirect_wb.valid || i_redirect_wb.target[2:0] == 3'b000) &&
        (!i_redirect_ex.valid || i_redirect_ex.target[2:0] == 3'b000) &&
        (!i_redirect_id.valid || i_redirect_id.target[2:0] == 3'b000));

endmodule

// ==== verilog/fetch_pkg.sv ====
`include "fetch_defines.svh"

package fetch_pkg;

    // pc override from a later stage
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

    // one instruction pair as handed to the decoder
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_DATA_W-1:0] inst0;
        logic [`FETCH_DATA_W-1:0] inst1;
    } fetch_pair_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]     id;
        logic [`FETCH_ADDR_W-1:0] addr;
        logic [7:0]               len;
        logic [2:0]               size;
        logic [1:0]               burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]     id;
        logic [`FETCH_DATA_W-1:0] data;
        logic [1:0]               resp;
        logic                     last;
    } axi_r_t;

endpackage

// ==== verilog/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// datapath widths
`define FETCH_ADDR_W    32
`define FETCH_DATA_W    32

// one fetch line is a single 16-beat burst
`define LINE_WORDS      16
`define LINE_OFFSET_W   6

// AXI4 read burst shape
`define AXI_ID_W        4
`define AXI_LEN_LINE    15
`define AXI_SIZE_WORD   2
`define AXI_BURST_INCR  1
`define FETCH_AXI_ID    0

// decoder-side queue
`define QUEUE_DEPTH     4
`define RESET_PC        32'h0000_0000

`endif
